// File: bp_pkg.sv
package bp_pkg;

    localparam int PC_W        = 32;
    localparam int HIST_W      = 10;
    localparam int GHIST_W     = 20;
    localparam int IDX_W       = 10;
    localparam int TABLE_N     = 1024;
    localparam int BTB_TAG_W   = 17;

    // PC slices for the table index and the target buffer tag
    localparam int PC_IDX_LSB  = 3;
    localparam int BTB_TAG_LSB = 13;

    // 2-bit saturating counter, shared by pattern tables and chooser
    typedef enum logic [1:0] {
        STRONG_NT = 2'b00,
        WEAK_NT   = 2'b01,
        WEAK_T    = 2'b10,
        STRONG_T  = 2'b11
    } ctr_e;

    // Which predictor the chooser picks
    typedef enum logic {
        SIDE_LOCAL  = 1'b0,
        SIDE_GLOBAL = 1'b1
    } side_e;

    // Upper half of the counter range means taken / global
    function automatic logic ctr_taken(ctr_e c);
        return (c == WEAK_T) || (c == STRONG_T);
    endfunction

    // One saturating step up or down
    function automatic ctr_e ctr_next(ctr_e c, logic up);
        ctr_e n;
        n = c;
        if (up) begin
            case (c)
                STRONG_NT: n = WEAK_NT;
                WEAK_NT:   n = WEAK_T;
                WEAK_T:    n = STRONG_T;
                default:   n = STRONG_T;
            endcase
        end else begin
            case (c)
                STRONG_T:  n = WEAK_T;
                WEAK_T:    n = WEAK_NT;
                WEAK_NT:   n = STRONG_NT;
                default:   n = STRONG_NT;
            endcase
        end
        return n;
    endfunction

endpackage

// File: branch_predict_unit.f
bp_pkg.sv
local_hist_predictor.sv
global_hist_predictor.sv
tournament_predictor.sv
target_buffer.sv
branch_predict_unit.sv
tb_branch_predict_unit.sv

// File: branch_predict_unit.sv
`timescale 1ns/1ps

module branch_predict_unit import bp_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [PC_W-1:0]  br_pc_i,
    input  logic             is_br_i,
    input  logic             is_j_i,
    input  logic             recover_i,
    input  logic             commit_valid_i,
    input  logic [IDX_W-1:0] commit_bht_index_i,
    input  logic [IDX_W-1:0] commit_pht_index_i,
    input  logic [IDX_W-1:0] commit_pht_index_g_i,
    input  logic [IDX_W-1:0] commit_cpht_index_i,
    input  logic             commit_use_global_i,
    input  logic [PC_W-1:0]  commit_pc_i,
    input  logic             commit_taken_i,
    input  logic [PC_W-1:0]  commit_target_i,
    input  logic             commit_mispred_i,
    output logic             pred_taken_o,
    output logic [PC_W-1:0]  pred_target_o,
    output logic             btb_hit_o,
    output logic [IDX_W-1:0] bht_index_o,
    output logic [IDX_W-1:0] pht_index_o,
    output logic [IDX_W-1:0] pht_index_g_o,
    output logic [IDX_W-1:0] cpht_index_o,
    output logic             use_global_o
);

    // Direction path
    tournament_predictor u_dir (
        .clk                  (clk),
        .rst                  (rst),
        .br_pc_i              (br_pc_i),
        .is_br_i              (is_br_i),
        .is_j_i               (is_j_i),
        .recover_i            (recover_i),
        .commit_valid_i       (commit_valid_i),
        .commit_bht_index_i   (commit_bht_index_i),
        .commit_pht_index_i   (commit_pht_index_i),
        .commit_pht_index_g_i (commit_pht_index_g_i),
        .commit_cpht_index_i  (commit_cpht_index_i),
        .commit_use_global_i  (commit_use_global_i),
        .commit_taken_i       (commit_taken_i),
        .commit_mispred_i     (commit_mispred_i),
        .pred_taken_o         (pred_taken_o),
        .bht_index_o          (bht_index_o),
        .pht_index_o          (pht_index_o),
        .pht_index_g_o        (pht_index_g_o),
        .cpht_index_o         (cpht_index_o),
        .use_global_o         (use_global_o)
    );

    // Target path, same two-cycle latency
    target_buffer u_btb (
        .clk             (clk),
        .rst             (rst),
        .br_pc_i         (br_pc_i),
        .commit_valid_i  (commit_valid_i),
        .commit_taken_i  (commit_taken_i),
        .commit_pc_i     (commit_pc_i),
        .commit_target_i (commit_target_i),
        .hit_o           (btb_hit_o),
        .target_o        (pred_target_o)
    );

endmodule

// File: global_hist_predictor.sv
`timescale 1ns/1ps

module global_hist_predictor import bp_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [PC_W-1:0]    br_pc_i,
    input  logic               recover_i,
    input  logic               spec_valid_i,
    input  logic               spec_taken_i,
    input  logic               commit_valid_i,
    input  logic [IDX_W-1:0]   commit_pht_index_g_i,
    input  logic               commit_taken_i,
    output logic               pred_taken_o,
    output logic [IDX_W-1:0]   pht_index_g_o,
    output logic [GHIST_W-1:0] ghist_o
);

    logic [GHIST_W-1:0] spec_ghist;
    logic [GHIST_W-1:0] committed_ghist;
    ctr_e               pht_g [TABLE_N];

    logic [IDX_W-1:0]   pht_index_g;
    logic               global_taken;

    // gshare index
    assign pht_index_g  = spec_ghist[IDX_W-1:0] ^ br_pc_i[PC_IDX_LSB +: IDX_W];
    assign global_taken = ctr_taken(pht_g[pht_index_g]);

    // Speculative history follows predictions, committed history follows retirement
    always_ff @(posedge clk) begin
        if (rst) begin
            spec_ghist      <= '0;
            committed_ghist <= '0;
        end else begin
            if (recover_i) begin
                spec_ghist <= committed_ghist;
            end else if (spec_valid_i) begin
                spec_ghist <= {spec_ghist[GHIST_W-2:0], spec_taken_i};
            end

            if (commit_valid_i) begin
                committed_ghist <= {committed_ghist[GHIST_W-2:0], commit_taken_i};
            end
        end
    end

    // Registered read, history sampled alongside the PC
    always_ff @(posedge clk) begin
        if (rst) begin
            pred_taken_o  <= 1'b0;
            pht_index_g_o <= '0;
            ghist_o       <= '0;
        end else begin
            pred_taken_o  <= global_taken;
            pht_index_g_o <= pht_index_g;
            ghist_o       <= spec_ghist;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_N; i++) begin
                pht_g[i] <= WEAK_NT;
            end
        end else if (commit_valid_i) begin
            pht_g[commit_pht_index_g_i] <= ctr_next(pht_g[commit_pht_index_g_i],
                                                    commit_taken_i);
        end
    end

endmodule

// File: local_hist_predictor.sv
`timescale 1ns/1ps

module local_hist_predictor import bp_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [PC_W-1:0]  br_pc_i,
    input  logic             commit_valid_i,
    input  logic [IDX_W-1:0] commit_bht_index_i,
    input  logic [IDX_W-1:0] commit_pht_index_i,
    input  logic             commit_taken_i,
    output logic             pred_taken_o,
    output logic [IDX_W-1:0] bht_index_o,
    output logic [IDX_W-1:0] pht_index_o,
    output logic [PC_W-1:0]  br_pc_o
);

    // Per-address history and the pattern table it addresses
    logic [HIST_W-1:0] bht [TABLE_N];
    ctr_e              pht [TABLE_N];

    logic [IDX_W-1:0]  bht_index;
    logic [IDX_W-1:0]  pht_index;
    logic              local_taken;

    assign bht_index = br_pc_i[PC_IDX_LSB +: IDX_W];

    // History of this branch selects its pattern counter
    assign pht_index   = bht[bht_index];
    assign local_taken = ctr_taken(pht[pht_index]);

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_taken_o <= 1'b0;
            bht_index_o  <= '0;
            pht_index_o  <= '0;
        end else begin
            pred_taken_o <= local_taken;
            bht_index_o  <= bht_index;
            pht_index_o  <= pht_index;
        end
    end

    // Delayed PC for the chooser stage
    always_ff @(posedge clk) begin
        br_pc_o <= br_pc_i;
    end

    // Training at commit
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_N; i++) begin
                bht[i] <= '0;
                pht[i] <= WEAK_NT;
            end
        end else if (commit_valid_i) begin
            bht[commit_bht_index_i] <= {bht[commit_bht_index_i][HIST_W-2:0], commit_taken_i};
            pht[commit_pht_index_i] <= ctr_next(pht[commit_pht_index_i], commit_taken_i);
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# Build with Verilator and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module tb_branch_predict_unit \
    -f branch_predict_unit.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qx "Finished with no errors" sim.log && echo "PASS" ||
{ echo "FAIL, see sim.log"; exit 1; }

// File: target_buffer.sv
`timescale 1ns/1ps

module target_buffer import bp_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic [PC_W-1:0] br_pc_i,
    input  logic            commit_valid_i,
    input  logic            commit_taken_i,
    input  logic [PC_W-1:0] commit_pc_i,
    input  logic [PC_W-1:0] commit_target_i,
    output logic            hit_o,
    output logic [PC_W-1:0] target_o
);

    logic                 btb_valid  [TABLE_N];
    logic [BTB_TAG_W-1:0] btb_tag    [TABLE_N];
    logic [PC_W-1:0]      btb_target [TABLE_N];

    logic [IDX_W-1:0]     rd_index;
    logic [BTB_TAG_W-1:0] rd_pc_tag;
    logic                 rd_match;
    logic [IDX_W-1:0]     wr_index;
    logic [BTB_TAG_W-1:0] wr_tag;

    // Stage 1 registers
    logic                 rd_hit_q;
    logic [PC_W-1:0]      rd_target_q;

    assign rd_index  = br_pc_i[PC_IDX_LSB +: IDX_W];
    assign rd_pc_tag = br_pc_i[BTB_TAG_LSB +: BTB_TAG_W];
    assign rd_match  = btb_valid[rd_index] && (btb_tag[rd_index] == rd_pc_tag);

    assign wr_index  = commit_pc_i[PC_IDX_LSB +: IDX_W];
    assign wr_tag    = commit_pc_i[BTB_TAG_LSB +: BTB_TAG_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_hit_q <= 1'b0;
        end else begin
            rd_hit_q <= rd_match;
        end
    end

    always_ff @(posedge clk) begin
        rd_target_q <= btb_target[rd_index];
    end

    // Stage 2, target reads as zero on a miss
    always_ff @(posedge clk) begin
        if (rst) begin
            hit_o    <= 1'b0;
            target_o <= '0;
        end else begin
            hit_o    <= rd_hit_q;
            target_o <= rd_hit_q ? rd_target_q : '0;
        end
    end

    // Only taken branches allocate
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_N; i++) begin
                btb_valid[i] <= 1'b0;
            end
        end else if (commit_valid_i && commit_taken_i) begin
            btb_valid[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (commit_valid_i && commit_taken_i) begin
            btb_tag[wr_index]    <= wr_tag;
            btb_target[wr_index] <= commit_target_i;
        end
    end

endmodule

// File: tb_branch_predict_unit.sv
`timescale 1ns/1ps

module tb_branch_predict_unit import bp_pkg::*; ();

    localparam int NUM_CYCLES  = 3000;
    localparam int CYCLE_LIMIT = 3200;
    localparam int ENTRY_W     = PC_W + 4 * IDX_W + 2;

    logic             clk;
    logic             rst;
    logic [PC_W-1:0]  br_pc;
    logic             is_br;
    logic             is_j;
    logic             recover;
    logic             commit_valid;
    logic [IDX_W-1:0] commit_bht_index;
    logic [IDX_W-1:0] commit_pht_index;
    logic [IDX_W-1:0] commit_pht_index_g;
    logic [IDX_W-1:0] commit_cpht_index;
    logic             commit_use_global;
    logic [PC_W-1:0]  commit_pc;
    logic             commit_taken;
    logic [PC_W-1:0]  commit_target;
    logic             commit_mispred;
    logic             pred_taken_o;
    logic [PC_W-1:0]  pred_target_o;
    logic             btb_hit_o;
    logic [IDX_W-1:0] bht_index_o;
    logic [IDX_W-1:0] pht_index_o;
    logic [IDX_W-1:0] pht_index_g_o;
    logic [IDX_W-1:0] cpht_index_o;
    logic             use_global_o;

    // Reference tables and histories
    logic [HIST_W-1:0]    m_bht [TABLE_N];
    logic [1:0]           m_pht [TABLE_N];
    logic [1:0]           m_pht_g [TABLE_N];
    logic [1:0]           m_cpht [TABLE_N];
    logic                 m_btb_valid [TABLE_N];
    logic [BTB_TAG_W-1:0] m_btb_tag [TABLE_N];
    logic [PC_W-1:0]      m_btb_target [TABLE_N];
    logic [GHIST_W-1:0]   m_spec;
    logic [GHIST_W-1:0]   m_comm;

    // Table read stage and expected outputs
    logic s1_local_taken, s1_global_taken, s1_hit;
    logic [IDX_W-1:0]   s1_bht, s1_pht, s1_pht_g;
    logic [GHIST_W-1:0] s1_ghist;
    logic [PC_W-1:0]    s1_pc, s1_target;
    logic e_taken, e_hit, e_use_global;
    logic [IDX_W-1:0]   e_bht, e_pht, e_pht_g, e_cpht;
    logic [PC_W-1:0]    e_pc, e_target;

    logic [PC_W-1:0]    addr_tab [32];
    logic [ENTRY_W-1:0] pending [$];
    integer             seed;
    int                 errors, checks, hits, global_picks, taken_preds, cycle_cnt;

    branch_predict_unit uut (
        .clk(clk), .rst(rst), .br_pc_i(br_pc), .is_br_i(is_br), .is_j_i(is_j),
        .recover_i(recover), .commit_valid_i(commit_valid),
        .commit_bht_index_i(commit_bht_index), .commit_pht_index_i(commit_pht_index),
        .commit_pht_index_g_i(commit_pht_index_g), .commit_cpht_index_i(commit_cpht_index),
        .commit_use_global_i(commit_use_global), .commit_pc_i(commit_pc),
        .commit_taken_i(commit_taken), .commit_target_i(commit_target),
        .commit_mispred_i(commit_mispred), .pred_taken_o(pred_taken_o),
        .pred_target_o(pred_target_o), .btb_hit_o(btb_hit_o), .bht_index_o(bht_index_o),
        .pht_index_o(pht_index_o), .pht_index_g_o(pht_index_g_o),
        .cpht_index_o(cpht_index_o), .use_global_o(use_global_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [1:0] sat_step(logic [1:0] c, logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic clear_model();
        for (int i = 0; i < TABLE_N; i++) begin
            m_bht[i] = '0;
            m_pht[i] = WEAK_NT;
            m_pht_g[i] = WEAK_NT;
            m_cpht[i] = WEAK_NT;
            m_btb_valid[i] = 1'b0;
            m_btb_tag[i] = '0;
            m_btb_target[i] = '0;
        end
        {m_spec, m_comm, s1_ghist} = '0;
        {s1_local_taken, s1_global_taken, s1_hit, s1_bht, s1_pht, s1_pht_g} = '0;
        {s1_pc, s1_target, e_pc, e_target} = '0;
        {e_taken, e_hit, e_use_global, e_bht, e_pht, e_pht_g, e_cpht} = '0;
    endtask

    // One clock edge of the predictor with all reads before any write
    task automatic step_model();
        logic [IDX_W-1:0] bi, pi, gi, ci;
        logic old_taken, up_global;
        bi = br_pc[12:3];
        pi = m_bht[bi];
        gi = m_spec[9:0] ^ bi;
        ci = s1_ghist[19:10] ^ s1_ghist[9:0] ^ s1_pc[12:3];
        old_taken = e_taken;
        e_use_global = (m_cpht[ci] >= WEAK_T);
        e_taken = e_use_global ? s1_global_taken : s1_local_taken;
        e_cpht = ci;
        {e_bht, e_pht, e_pht_g, e_pc} = {s1_bht, s1_pht, s1_pht_g, s1_pc};
        e_hit = s1_hit;
        e_target = s1_hit ? s1_target : '0;
        s1_local_taken = (m_pht[pi] >= WEAK_T);
        s1_global_taken = (m_pht_g[gi] >= WEAK_T);
        {s1_bht, s1_pht, s1_pht_g, s1_ghist, s1_pc} = {bi, pi, gi, m_spec, br_pc};
        s1_hit = m_btb_valid[bi] && (m_btb_tag[bi] == br_pc[29:13]);
        s1_target = m_btb_target[bi];
        if (recover) begin
            m_spec = m_comm;
        end else if (is_br || is_j) begin
            m_spec = {m_spec[GHIST_W-2:0], old_taken | is_j};
        end
        if (commit_valid) begin
            m_comm = {m_comm[GHIST_W-2:0], commit_taken};
            m_bht[commit_bht_index] = {m_bht[commit_bht_index][HIST_W-2:0], commit_taken};
            m_pht[commit_pht_index] = sat_step(m_pht[commit_pht_index], commit_taken);
            m_pht_g[commit_pht_index_g] = sat_step(m_pht_g[commit_pht_index_g], commit_taken);
            // Wrong side loses a step, right side gains one
            up_global = commit_use_global ? !commit_mispred : commit_mispred;
            m_cpht[commit_cpht_index] = sat_step(m_cpht[commit_cpht_index], up_global);
            if (commit_taken) begin
                m_btb_valid[commit_pc[12:3]] = 1'b1;
                m_btb_tag[commit_pc[12:3]] = commit_pc[29:13];
                m_btb_target[commit_pc[12:3]] = commit_target;
            end
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] rnd;
        logic        pred;
        rnd = $random(seed);
        br_pc = addr_tab[rnd[4:0]];
        is_br = rnd[5];
        is_j = (rnd[8:6] == 3'd0);
        recover = (rnd[13:9] == 5'd0);
        if (pending.size() > 0 && rnd[15:14] != 2'd0) begin
            {commit_pc, commit_bht_index, commit_pht_index, commit_pht_index_g,
             commit_cpht_index, commit_use_global, pred} = pending.pop_front();
            commit_valid = 1'b1;
            // Odd index entries lean taken, even ones lean not-taken
            commit_taken = commit_pc[3] ? (rnd[18:16] != 3'd0) : (rnd[18:16] == 3'd0);
            commit_mispred = (commit_taken != pred);
            commit_target = commit_pc + 32'h0000_0100;
        end else begin
            commit_valid = 1'b0;
            {commit_bht_index, commit_pht_index, commit_pht_index_g, commit_cpht_index} = '0;
            {commit_use_global, commit_pc, commit_taken, commit_target, commit_mispred} = '0;
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] cycle %0d %s: got %h expected %h", cycle_cnt, name, got, exp);
        end
    endtask

    task automatic check_outputs();
        check_field("pred_taken_o", 32'(pred_taken_o), 32'(e_taken));
        check_field("pred_target_o", pred_target_o, e_target);
        check_field("btb_hit_o", 32'(btb_hit_o), 32'(e_hit));
        check_field("bht_index_o", 32'(bht_index_o), 32'(e_bht));
        check_field("pht_index_o", 32'(pht_index_o), 32'(e_pht));
        check_field("pht_index_g_o", 32'(pht_index_g_o), 32'(e_pht_g));
        check_field("cpht_index_o", 32'(cpht_index_o), 32'(e_cpht));
        check_field("use_global_o", 32'(use_global_o), 32'(e_use_global));
        hits += int'(e_hit);
        global_picks += int'(e_use_global);
        taken_preds += int'(e_taken);
    endtask

    // Watchdog
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not end within %0d cycles, errors %0d", CYCLE_LIMIT, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        seed = 24;
        {errors, checks, hits, global_picks, taken_preds} = '0;
        rst = 1'b1;
        {br_pc, is_br, is_j, recover, commit_valid, commit_bht_index} = '0;
        {commit_pht_index, commit_pht_index_g, commit_cpht_index, commit_use_global} = '0;
        {commit_pc, commit_taken, commit_target, commit_mispred} = '0;
        // Pairs of addresses share an index under different tags
        for (int k = 0; k < 32; k++) begin
            addr_tab[k] = {2'b00, (k[4] ? 17'h1A5 : 17'h0C3), 10'(k[3:0] * 37 + 5), 3'b000};
        end
        clear_model();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        // Cleared model expects every output at zero
        check_outputs();
        for (int n = 0; n < NUM_CYCLES; n++) begin
            drive_inputs();
            step_model();
            pending.push_back({e_pc, e_bht, e_pht, e_pht_g, e_cpht, e_use_global, e_taken});
            if (pending.size() > 8) begin
                void'(pending.pop_front());
            end
            @(posedge clk);
            #1;
            check_outputs();
        end
        if (hits == 0) begin
            errors++;
            $display("The target buffer never hit during the run");
        end
        if (global_picks == 0) begin
            errors++;
            $display("The chooser never selected the global predictor");
        end
        if (taken_preds == 0) begin
            errors++;
            $display("No prediction was taken during the run");
        end
        $display("Checks %0d, errors %0d, btb hits %0d, global picks %0d, taken %0d",
                 checks, errors, hits, global_picks, taken_preds);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: tournament_predictor.sv
`timescale 1ns/1ps

module tournament_predictor import bp_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic [PC_W-1:0]  br_pc_i,
    input  logic             is_br_i,
    input  logic             is_j_i,
    input  logic             recover_i,
    input  logic             commit_valid_i,
    input  logic [IDX_W-1:0] commit_bht_index_i,
    input  logic [IDX_W-1:0] commit_pht_index_i,
    input  logic [IDX_W-1:0] commit_pht_index_g_i,
    input  logic [IDX_W-1:0] commit_cpht_index_i,
    input  logic             commit_use_global_i,
    input  logic             commit_taken_i,
    input  logic             commit_mispred_i,
    output logic             pred_taken_o,
    output logic [IDX_W-1:0] bht_index_o,
    output logic [IDX_W-1:0] pht_index_o,
    output logic [IDX_W-1:0] pht_index_g_o,
    output logic [IDX_W-1:0] cpht_index_o,
    output logic             use_global_o
);

    logic               local_taken;
    logic               global_taken;
    logic [IDX_W-1:0]   local_bht_index;
    logic [IDX_W-1:0]   local_pht_index;
    logic [IDX_W-1:0]   global_pht_index_g;
    logic [GHIST_W-1:0] ghist_dly;
    logic [PC_W-1:0]    br_pc_dly;

    logic               spec_valid;
    logic               spec_taken;

    ctr_e               cpht [TABLE_N];
    logic [IDX_W-1:0]   cpht_index;
    side_e              sel_side;
    logic               sel_taken;

    side_e              commit_side;
    logic               step_global;

    // Outcome of the instruction now leaving the output stage
    assign spec_valid = is_br_i | is_j_i;
    assign spec_taken = pred_taken_o | is_j_i;

    local_hist_predictor u_local (
        .clk                (clk),
        .rst                (rst),
        .br_pc_i            (br_pc_i),
        .commit_valid_i     (commit_valid_i),
        .commit_bht_index_i (commit_bht_index_i),
        .commit_pht_index_i (commit_pht_index_i),
        .commit_taken_i     (commit_taken_i),
        .pred_taken_o       (local_taken),
        .bht_index_o        (local_bht_index),
        .pht_index_o        (local_pht_index),
        .br_pc_o            (br_pc_dly)
    );

    global_hist_predictor u_global (
        .clk                  (clk),
        .rst                  (rst),
        .br_pc_i              (br_pc_i),
        .recover_i            (recover_i),
        .spec_valid_i         (spec_valid),
        .spec_taken_i         (spec_taken),
        .commit_valid_i       (commit_valid_i),
        .commit_pht_index_g_i (commit_pht_index_g_i),
        .commit_taken_i       (commit_taken_i),
        .pred_taken_o         (global_taken),
        .pht_index_g_o        (global_pht_index_g),
        .ghist_o              (ghist_dly)
    );

    assign cpht_index = ghist_dly[GHIST_W-1:IDX_W] ^ ghist_dly[IDX_W-1:0]
                      ^ br_pc_dly[PC_IDX_LSB +: IDX_W];

    always_comb begin
        sel_side  = ctr_taken(cpht[cpht_index]) ? SIDE_GLOBAL : SIDE_LOCAL;
        sel_taken = (sel_side == SIDE_GLOBAL) ? global_taken : local_taken;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_taken_o  <= 1'b0;
            bht_index_o   <= '0;
            pht_index_o   <= '0;
            pht_index_g_o <= '0;
            cpht_index_o  <= '0;
            use_global_o  <= 1'b0;
        end else begin
            pred_taken_o  <= sel_taken;
            bht_index_o   <= local_bht_index;
            pht_index_o   <= local_pht_index;
            pht_index_g_o <= global_pht_index_g;
            cpht_index_o  <= cpht_index;
            use_global_o  <= (sel_side == SIDE_GLOBAL);
        end
    end

    assign commit_side = commit_use_global_i ? SIDE_GLOBAL : SIDE_LOCAL;
    // Mispredict pushes away from the used side, a hit pushes toward it
    assign step_global = (commit_side == SIDE_GLOBAL) ^ commit_mispred_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < TABLE_N; i++) begin
                cpht[i] <= WEAK_NT;
            end
        end else if (commit_valid_i) begin
            cpht[commit_cpht_index_i] <= ctr_next(cpht[commit_cpht_index_i], step_global);
        end
    end

endmodule
